// File: hdl/ft_alu_pkg.sv
// fault-tolerant ALU shared definitions
// opcodes, spare FSM states, replica indexing and replica/lane counts
`default_nettype none

package ft_alu_pkg;

	////////////////////////////////////////////////////////////////////////////
	// replica and lane geometry
	////////////////////////////////////////////////////////////////////////////

	// four identical replicas, one of them held back as spare
	localparam int unsigned NUM_ALU = 4;

	// three replicas feed the majority vote at any time
	localparam int unsigned NUM_LANES = 3;

	// replica index, wide enough for NUM_ALU
	typedef logic [1:0] alu_idx_t;

	// replica kept out of the vote until a lane needs it
	localparam alu_idx_t SPARE_IDX = 2'd3;

	////////////////////////////////////////////////////////////////////////////
	// operation and state encodings
	////////////////////////////////////////////////////////////////////////////

	// ALU opcodes, the last three produce a comparison flag
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SLL = 4'd5,
		ALU_SRL = 4'd6,
		ALU_EQ  = 4'd7,
		ALU_LT  = 4'd8,
		ALU_LTU = 4'd9
	} alu_op_e;

	// spare replica usage, one-way once the spare is in a lane
	typedef enum logic {
		SPARE_IDLE   = 1'b0,
		SPARE_IN_USE = 1'b1
	} spare_state_e;

endpackage : ft_alu_pkg

`default_nettype wire

// File: hdl/alu_core.sv
// single ALU replica, purely combinational
// result can be corrupted by an XOR injection mask for fault campaigns
`default_nettype none

module alu_core #(
	parameter int unsigned DATA_WIDTH = 32
) (
	input  ft_alu_pkg::alu_op_e    operator_i,
	input  logic [DATA_WIDTH-1:0]  operand_a_i,
	input  logic [DATA_WIDTH-1:0]  operand_b_i,
	input  logic [DATA_WIDTH-1:0]  fault_mask_i,
	output logic [DATA_WIDTH-1:0]  result_o,
	output logic                   cmp_o
);

	// shift amount taken from the low bits of operand b
	localparam int unsigned SHAMT_W = $clog2(DATA_WIDTH);

	logic [SHAMT_W-1:0]    shamt;
	logic [DATA_WIDTH-1:0] res_raw;
	logic                  cmp_raw;

	assign shamt = operand_b_i[SHAMT_W-1:0];

	////////////////////////////////////////////////////////////////////////////
	// operation decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		res_raw = '0;
		cmp_raw = 1'b0;
		case (operator_i)
			ft_alu_pkg::ALU_ADD: begin
				res_raw = operand_a_i + operand_b_i;
			end
			ft_alu_pkg::ALU_SUB: begin
				res_raw = operand_a_i - operand_b_i;
			end
			ft_alu_pkg::ALU_AND: begin
				res_raw = operand_a_i & operand_b_i;
			end
			ft_alu_pkg::ALU_OR: begin
				res_raw = operand_a_i | operand_b_i;
			end
			ft_alu_pkg::ALU_XOR: begin
				res_raw = operand_a_i ^ operand_b_i;
			end
			ft_alu_pkg::ALU_SLL: begin
				res_raw = operand_a_i << shamt;
			end
			ft_alu_pkg::ALU_SRL: begin
				res_raw = operand_a_i >> shamt;
			end
			// comparisons drive the flag and a zero-extended copy on the result
			ft_alu_pkg::ALU_EQ: begin
				cmp_raw = (operand_a_i == operand_b_i);
				res_raw = {{(DATA_WIDTH-1){1'b0}}, cmp_raw};
			end
			ft_alu_pkg::ALU_LT: begin
				cmp_raw = ($signed(operand_a_i) < $signed(operand_b_i));
				res_raw = {{(DATA_WIDTH-1){1'b0}}, cmp_raw};
			end
			ft_alu_pkg::ALU_LTU: begin
				cmp_raw = (operand_a_i < operand_b_i);
				res_raw = {{(DATA_WIDTH-1){1'b0}}, cmp_raw};
			end
			// unused encodings give zero
			default: begin
				res_raw = '0;
				cmp_raw = 1'b0;
			end
		endcase
	end

	// injection only touches the result, the flag stays clean
	assign result_o = res_raw ^ fault_mask_i;
	assign cmp_o    = cmp_raw;

endmodule : alu_core

`default_nettype wire

// File: hdl/tmr_voter.sv
// triple-modular voter, picks three of four replicas through the lane map
// bitwise majority on result and flag, per-lane mismatch and error reporting
`default_nettype none

module tmr_voter #(
	parameter int unsigned DATA_WIDTH = 32
) (
	input  logic [ft_alu_pkg::NUM_ALU-1:0][DATA_WIDTH-1:0]      result_i,
	input  logic [ft_alu_pkg::NUM_ALU-1:0]                      cmp_i,
	input  ft_alu_pkg::alu_idx_t [ft_alu_pkg::NUM_LANES-1:0]    lane_map_i,
	input  logic                                                enable_i,
	output logic [DATA_WIDTH-1:0]                               result_o,
	output logic                                                cmp_o,
	output logic [ft_alu_pkg::NUM_LANES-1:0]                    lane_err_o,
	output logic                                                err_detected_o,
	output logic                                                err_corrected_o
);

	logic [ft_alu_pkg::NUM_LANES-1:0][DATA_WIDTH-1:0] lane_res;
	logic [ft_alu_pkg::NUM_LANES-1:0]                 lane_cmp;
	logic [ft_alu_pkg::NUM_LANES-1:0]                 lane_diff;

	////////////////////////////////////////////////////////////////////////////
	// lane muxes
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int l = 0; l < ft_alu_pkg::NUM_LANES; l++) begin
			lane_res[l] = result_i[lane_map_i[l]];
			lane_cmp[l] = cmp_i[lane_map_i[l]];
		end
	end

	// 2-of-3 majority, bit by bit
	assign result_o = (lane_res[0] & lane_res[1]) |
	                  (lane_res[0] & lane_res[2]) |
	                  (lane_res[1] & lane_res[2]);
	assign cmp_o    = (lane_cmp[0] & lane_cmp[1]) |
	                  (lane_cmp[0] & lane_cmp[2]) |
	                  (lane_cmp[1] & lane_cmp[2]);

	////////////////////////////////////////////////////////////////////////////
	// error classification
	////////////////////////////////////////////////////////////////////////////

	// a lane is wrong if either its result or its flag lost the vote
	always_comb begin
		for (int l = 0; l < ft_alu_pkg::NUM_LANES; l++) begin
			lane_diff[l] = (lane_res[l] != result_o) || (lane_cmp[l] != cmp_o);
		end
	end

	// idle cycles never report, so the monitor does not count them either
	assign lane_err_o = lane_diff & {ft_alu_pkg::NUM_LANES{enable_i}};

	assign err_detected_o = |lane_err_o;

	// with a bitwise vote two lanes can only fail together when all three differ
	// and the vote lands on the third; that case is still a correction
	// only a vote matching no lane at all is uncorrected
	assign err_corrected_o = err_detected_o && !(&lane_err_o);

endmodule : tmr_voter

`default_nettype wire

// File: hdl/fault_monitor.sv
// fault monitor for the replicated ALU
// per-replica saturating error counters, faulty flags and one-shot spare swap
`default_nettype none

module fault_monitor #(
	parameter int unsigned CNT_WIDTH       = 8,
	parameter int unsigned FAULT_THRESHOLD = 4
) (
	input  logic                                              clk_i,
	input  logic                                              rst_n_i,
	input  logic [ft_alu_pkg::NUM_LANES-1:0]                  lane_err_i,
	input  ft_alu_pkg::alu_idx_t                              cnt_idx_i,
	output ft_alu_pkg::alu_idx_t [ft_alu_pkg::NUM_LANES-1:0]  lane_map_o,
	output logic [ft_alu_pkg::NUM_ALU-1:0]                    faulty_o,
	output logic [CNT_WIDTH-1:0]                              cnt_o
);

	// saturation value of every counter
	localparam logic [CNT_WIDTH-1:0] CNT_MAX = {CNT_WIDTH{1'b1}};

	logic [ft_alu_pkg::NUM_ALU-1:0][CNT_WIDTH-1:0]    cnt_q;
	logic [ft_alu_pkg::NUM_ALU-1:0][CNT_WIDTH-1:0]    cnt_d;
	logic [ft_alu_pkg::NUM_ALU-1:0]                   faulty_q;
	logic [ft_alu_pkg::NUM_ALU-1:0]                   faulty_d;
	ft_alu_pkg::alu_idx_t [ft_alu_pkg::NUM_LANES-1:0] lane_map_q;
	ft_alu_pkg::alu_idx_t [ft_alu_pkg::NUM_LANES-1:0] lane_map_d;
	ft_alu_pkg::spare_state_e                         state_q;
	ft_alu_pkg::spare_state_e                         state_d;

	////////////////////////////////////////////////////////////////////////////
	// next-state logic
	////////////////////////////////////////////////////////////////////////////

	always_comb begin : monitor_next
		logic                 swapped;
		ft_alu_pkg::alu_idx_t idx;

		cnt_d      = cnt_q;
		faulty_d   = faulty_q;
		lane_map_d = lane_map_q;
		state_d    = state_q;
		swapped    = 1'b0;

		// charge each lane error to the replica sitting in that lane
		// unmapped replicas (idle spare, swapped-out unit) never move
		for (int l = 0; l < ft_alu_pkg::NUM_LANES; l++) begin
			idx = lane_map_q[l];
			if (lane_err_i[l] && (cnt_q[idx] != CNT_MAX)) begin
				cnt_d[idx] = cnt_q[idx] + 1'b1;
			end
		end

		// sticky fault flags, judged on the updated count
		for (int i = 0; i < ft_alu_pkg::NUM_ALU; i++) begin
			if (cnt_d[i] >= FAULT_THRESHOLD) begin
				faulty_d[i] = 1'b1;
			end
		end

		// spare FSM: first new fault pulls the spare in, lowest lane wins
		if (state_q == ft_alu_pkg::SPARE_IDLE) begin
			for (int l = 0; l < ft_alu_pkg::NUM_LANES; l++) begin
				idx = lane_map_q[l];
				if (!swapped && faulty_d[idx] && !faulty_q[idx]) begin
					lane_map_d[l] = ft_alu_pkg::SPARE_IDX;
					state_d       = ft_alu_pkg::SPARE_IN_USE;
					swapped       = 1'b1;
				end
			end
		end
		// once in use, later faults only raise flags
	end

	////////////////////////////////////////////////////////////////////////////
	// state registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt_q    <= '0;
			faulty_q <= '0;
			state_q  <= ft_alu_pkg::SPARE_IDLE;
			// identity mapping, lane n holds replica n
			for (int l = 0; l < ft_alu_pkg::NUM_LANES; l++) begin
				lane_map_q[l] <= ft_alu_pkg::alu_idx_t'(l);
			end
		end else begin
			cnt_q      <= cnt_d;
			faulty_q   <= faulty_d;
			lane_map_q <= lane_map_d;
			state_q    <= state_d;
		end
	end

	assign lane_map_o = lane_map_q;
	assign faulty_o   = faulty_q;

	// counter read port, no latency
	assign cnt_o = cnt_q[cnt_idx_i];

endmodule : fault_monitor

`default_nettype wire

// File: hdl/ft_alu_top.sv
// fault-tolerant ALU top level
// four replicas, a TMR voter and the fault monitor that steers the spare
`default_nettype none

module ft_alu_top #(
	parameter int unsigned DATA_WIDTH      = 32,
	parameter int unsigned CNT_WIDTH       = 8,
	parameter int unsigned FAULT_THRESHOLD = 4
) (
	input  logic                                              clk_i,
	input  logic                                              rst_n_i,
	input  logic                                              enable_i,
	input  ft_alu_pkg::alu_op_e                               op_i,
	input  logic [DATA_WIDTH-1:0]                             operand_a_i,
	input  logic [DATA_WIDTH-1:0]                             operand_b_i,
	input  logic [ft_alu_pkg::NUM_ALU-1:0][DATA_WIDTH-1:0]    fault_mask_i,
	input  ft_alu_pkg::alu_idx_t                              cnt_idx_i,
	output logic [DATA_WIDTH-1:0]                             result_o,
	output logic                                              cmp_o,
	output logic                                              err_detected_o,
	output logic                                              err_corrected_o,
	output logic [ft_alu_pkg::NUM_ALU-1:0]                    faulty_o,
	output ft_alu_pkg::alu_idx_t [ft_alu_pkg::NUM_LANES-1:0]  lane_map_o,
	output logic [CNT_WIDTH-1:0]                              cnt_o
);

	// replica outputs toward the voter
	logic [ft_alu_pkg::NUM_ALU-1:0][DATA_WIDTH-1:0] alu_result;
	logic [ft_alu_pkg::NUM_ALU-1:0]                 alu_cmp;
	// lane error feedback into the monitor
	logic [ft_alu_pkg::NUM_LANES-1:0]               lane_err;

	////////////////////////////////////////////////////////////////////////////
	// replicas, all fed the same operation
	////////////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < ft_alu_pkg::NUM_ALU; g++) begin : gen_alu
		alu_core #(
			.DATA_WIDTH (DATA_WIDTH)
		) i_alu_core (
			.operator_i   (op_i),
			.operand_a_i  (operand_a_i),
			.operand_b_i  (operand_b_i),
			.fault_mask_i (fault_mask_i[g]),
			.result_o     (alu_result[g]),
			.cmp_o        (alu_cmp[g])
		);
	end

	tmr_voter #(
		.DATA_WIDTH (DATA_WIDTH)
	) i_tmr_voter (
		.result_i        (alu_result),
		.cmp_i           (alu_cmp),
		.lane_map_i      (lane_map_o),
		.enable_i        (enable_i),
		.result_o        (result_o),
		.cmp_o           (cmp_o),
		.lane_err_o      (lane_err),
		.err_detected_o  (err_detected_o),
		.err_corrected_o (err_corrected_o)
	);

	fault_monitor #(
		.CNT_WIDTH       (CNT_WIDTH),
		.FAULT_THRESHOLD (FAULT_THRESHOLD)
	) i_fault_monitor (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.lane_err_i (lane_err),
		.cnt_idx_i  (cnt_idx_i),
		.lane_map_o (lane_map_o),
		.faulty_o   (faulty_o),
		.cnt_o      (cnt_o)
	);

endmodule : ft_alu_top

`default_nettype wire

// File: bench/ft_alu_props.sv
// bound checks on the voter flags and the fault monitor state
// attached to the top level, which holds both the voter and the monitor
`default_nettype none

module ft_alu_props #(
	parameter int unsigned DATA_WIDTH = 32
) (
	input  logic                                              clk_i,
	input  logic                                              rst_n_i,
	input  logic [ft_alu_pkg::NUM_ALU-1:0][DATA_WIDTH-1:0]    alu_result_i,
	input  logic [ft_alu_pkg::NUM_ALU-1:0]                    alu_cmp_i,
	input  logic [DATA_WIDTH-1:0]                             result_i,
	input  logic                                              cmp_i,
	input  logic                                              err_detected_i,
	input  logic                                              err_corrected_i,
	input  ft_alu_pkg::alu_idx_t [ft_alu_pkg::NUM_LANES-1:0]  lane_map_i,
	input  logic [ft_alu_pkg::NUM_ALU-1:0]                    faulty_i,
	input  ft_alu_pkg::spare_state_e                          state_i
);

	// voted word and flag equal those of at least one replica in the lanes
	logic vote_on_lane;

	always_comb begin
		vote_on_lane = 1'b0;
		for (int l = 0; l < ft_alu_pkg::NUM_LANES; l++) begin
			if ((alu_result_i[lane_map_i[l]] == result_i) &&
			    (alu_cmp_i[lane_map_i[l]] == cmp_i)) begin
				vote_on_lane = 1'b1;
			end
		end
	end

	// a correction is a detection whose vote lands on one of the lanes
	a_corr_needs_det: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		err_corrected_i |-> (err_detected_i && vote_on_lane))
		else $error("err_corrected high without a detection or a lane matching the vote");

	// no replica may sit in two lanes
	a_map_distinct: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(lane_map_i[0] != lane_map_i[1]) && (lane_map_i[0] != lane_map_i[2]) &&
		(lane_map_i[1] != lane_map_i[2]))
		else $error("lane map holds a replica twice");

	// faulty flags are sticky until reset
	a_faulty_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(faulty_i & $past(faulty_i)) == $past(faulty_i))
		else $error("a faulty flag cleared");

	// the spare FSM is one-way
	a_spare_one_way: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(state_i == ft_alu_pkg::SPARE_IN_USE) |=> (state_i == ft_alu_pkg::SPARE_IN_USE))
		else $error("spare state went back to idle");

endmodule : ft_alu_props

bind ft_alu_top ft_alu_props #(
	.DATA_WIDTH (DATA_WIDTH)
) i_ft_alu_props (
	.clk_i           (clk_i),
	.rst_n_i         (rst_n_i),
	.alu_result_i    (alu_result),
	.alu_cmp_i       (alu_cmp),
	.result_i        (result_o),
	.cmp_i           (cmp_o),
	.err_detected_i  (err_detected_o),
	.err_corrected_i (err_corrected_o),
	.lane_map_i      (lane_map_o),
	.faulty_i        (faulty_o),
	.state_i         (i_fault_monitor.state_q)
);

`default_nettype wire

// File: bench/ft_alu_tb.sv
// directed testbench for the fault-tolerant ALU
// voting, error counting, spare swap, idle gating, readout and reset
`default_nettype none

module ft_alu_tb;

	localparam int unsigned DATA_WIDTH      = 32;
	localparam int unsigned CNT_WIDTH       = 8;
	localparam int unsigned FAULT_THRESHOLD = 4;
	localparam int unsigned NUM_ALU         = ft_alu_pkg::NUM_ALU;
	localparam int unsigned NUM_LANES       = ft_alu_pkg::NUM_LANES;

	// cycles per test, the run limit is twice the sum
	localparam int unsigned REPS      = 3;
	localparam int unsigned READ_LEN  = NUM_ALU;
	localparam int unsigned RESET_LEN = 3;
	localparam int unsigned TEST_LEN  = RESET_LEN + (10 * REPS + READ_LEN) + (1 + READ_LEN) +
		(FAULT_THRESHOLD + READ_LEN + 2) + (FAULT_THRESHOLD + READ_LEN) + (3 + READ_LEN) +
		(RESET_LEN + READ_LEN + 1);
	localparam int unsigned TIMEOUT_CYCLES = 2 * TEST_LEN;

	typedef logic [NUM_ALU-1:0][DATA_WIDTH-1:0]   mask_t;
	typedef ft_alu_pkg::alu_idx_t [NUM_LANES-1:0] map_t;
	typedef logic [DATA_WIDTH-1:0]                word_t;
	typedef logic [CNT_WIDTH-1:0]                 count_t;

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic                 enable;
	ft_alu_pkg::alu_op_e  op;
	word_t                operand_a;
	word_t                operand_b;
	mask_t                fault_mask;
	ft_alu_pkg::alu_idx_t cnt_idx;
	word_t                result;
	logic                 cmp;
	logic                 err_detected;
	logic                 err_corrected;
	logic [NUM_ALU-1:0]   faulty;
	map_t                 lane_map;
	count_t               cnt;

	// expected monitor state, tallied by the tests
	count_t               exp_cnt [NUM_ALU];
	logic [NUM_ALU-1:0]   exp_faulty;
	map_t                 exp_map;
	logic [31:0]          lfsr;
	int unsigned          cycle_cnt = 0;

	ft_alu_top #(
		.DATA_WIDTH      (DATA_WIDTH),
		.CNT_WIDTH       (CNT_WIDTH),
		.FAULT_THRESHOLD (FAULT_THRESHOLD)
	) uut (
		.clk_i           (clk),
		.rst_n_i         (rst_n),
		.enable_i        (enable),
		.op_i            (op),
		.operand_a_i     (operand_a),
		.operand_b_i     (operand_b),
		.fault_mask_i    (fault_mask),
		.cnt_idx_i       (cnt_idx),
		.result_o        (result),
		.cmp_o           (cmp),
		.err_detected_o  (err_detected),
		.err_corrected_o (err_corrected),
		.faulty_o        (faulty),
		.lane_map_o      (lane_map),
		.cnt_o           (cnt)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			abort_run("timeout: the tests did not finish within the cycle limit");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one LFSR step per bit taken
	task automatic rand_word(output word_t w);
		w = '0;
		for (int k = 0; k < DATA_WIDTH; k++) begin
			w    = {w[DATA_WIDTH-2:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// expected result and flag straight from the opcode rules
	function automatic void ref_alu(input ft_alu_pkg::alu_op_e o, input word_t a, input word_t b,
		output word_t res, output logic flag);
		word_t msb;
		msb  = word_t'(1) << (DATA_WIDTH - 1);
		res  = '0;
		flag = 1'b0;
		case (o)
			ft_alu_pkg::ALU_ADD: res = a + b;
			ft_alu_pkg::ALU_SUB: res = a - b;
			ft_alu_pkg::ALU_AND: res = a & b;
			ft_alu_pkg::ALU_OR:  res = a | b;
			ft_alu_pkg::ALU_XOR: res = a ^ b;
			ft_alu_pkg::ALU_SLL: res = a << (b % DATA_WIDTH);
			ft_alu_pkg::ALU_SRL: res = a >> (b % DATA_WIDTH);
			ft_alu_pkg::ALU_EQ:  flag = (a == b);
			// signed order by flipping the sign bits
			ft_alu_pkg::ALU_LT:  flag = ((a ^ msb) < (b ^ msb));
			ft_alu_pkg::ALU_LTU: flag = (a < b);
			default: res = '0;
		endcase
		if (o == ft_alu_pkg::ALU_EQ || o == ft_alu_pkg::ALU_LT || o == ft_alu_pkg::ALU_LTU) begin
			res = word_t'(flag);
		end
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_map(input map_t got, input map_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR lane_map_o got 0x%h expected 0x%h", got, exp));
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic clear_expect();
		for (int i = 0; i < NUM_ALU; i++) begin
			exp_cnt[i] = '0;
		end
		exp_faulty = '0;
		exp_map    = {2'd2, 2'd1, 2'd0};
	endtask

	// one operation, outputs sampled mid-cycle
	task automatic run_op(input logic en, input ft_alu_pkg::alu_op_e o, input word_t a,
		input word_t b, input mask_t masks, input logic exp_det, input logic exp_corr);
		word_t exp_res;
		logic  exp_cmp;
		ref_alu(o, a, b, exp_res, exp_cmp);
		@(posedge clk);
		enable     <= en;
		op         <= o;
		operand_a  <= a;
		operand_b  <= b;
		fault_mask <= masks;
		@(negedge clk);
		if (en) begin
			check_word("result_o", result, exp_res);
			check_flag("cmp_o", cmp, exp_cmp);
		end
		check_flag("err_detected_o", err_detected, exp_det);
		check_flag("err_corrected_o", err_corrected, exp_corr);
	endtask

	// idle cycles that walk the counter read port
	task automatic check_state();
		for (int i = 0; i < NUM_ALU; i++) begin
			@(posedge clk);
			enable     <= 1'b0;
			fault_mask <= '0;
			cnt_idx    <= ft_alu_pkg::alu_idx_t'(i);
			@(negedge clk);
			check_count($sformatf("cnt_o[%0d]", i), cnt, exp_cnt[i]);
			check_flag($sformatf("faulty_o[%0d]", i), faulty[i], exp_faulty[i]);
			check_map(lane_map, exp_map);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_fault_free();
		word_t               a, b;
		ft_alu_pkg::alu_op_e o;
		for (int k = 0; k <= int'(ft_alu_pkg::ALU_LTU); k++) begin
			o = ft_alu_pkg::alu_op_e'(k);
			for (int r = 0; r < REPS; r++) begin
				rand_word(a);
				rand_word(b);
				// one equal pair so ALU_EQ sees a true result
				if (r == 0 && o == ft_alu_pkg::ALU_EQ) b = a;
				run_op(1'b1, o, a, b, '0, 1'b0, 1'b0);
			end
		end
		check_state();
	endtask

	task automatic test_single_lane();
		word_t a, b, m;
		mask_t masks;
		rand_word(a);
		rand_word(b);
		rand_word(m);
		masks    = '0;
		masks[1] = m | word_t'(1);
		run_op(1'b1, ft_alu_pkg::ALU_ADD, a, b, masks, 1'b1, 1'b1);
		exp_cnt[1] = exp_cnt[1] + 1'b1;
		check_state();
	endtask

	task automatic test_perm_fault();
		word_t a, b, m;
		mask_t masks;
		rand_word(m);
		masks    = '0;
		masks[0] = m | word_t'(1);
		for (int n = 0; n < FAULT_THRESHOLD; n++) begin
			rand_word(a);
			rand_word(b);
			run_op(1'b1, ft_alu_pkg::ALU_SUB, a, b, masks, 1'b1, 1'b1);
		end
		// spare takes lane 0 on the next edge
		exp_cnt[0]    = exp_cnt[0] + count_t'(FAULT_THRESHOLD);
		exp_faulty[0] = 1'b1;
		exp_map[0]    = ft_alu_pkg::SPARE_IDX;
		check_state();
		// replica 0 is out of the vote now
		for (int n = 0; n < 2; n++) begin
			rand_word(a);
			rand_word(b);
			run_op(1'b1, ft_alu_pkg::ALU_XOR, a, b, masks, 1'b0, 1'b0);
		end
	endtask

	task automatic test_spare_exhaust();
		word_t a, b, m;
		mask_t masks;
		rand_word(m);
		masks    = '0;
		masks[2] = m | word_t'(1);
		for (int n = 0; n < FAULT_THRESHOLD; n++) begin
			rand_word(a);
			rand_word(b);
			run_op(1'b1, ft_alu_pkg::ALU_AND, a, b, masks, 1'b1, 1'b1);
		end
		// no spare left, map stays as it is
		exp_cnt[2]    = exp_cnt[2] + count_t'(FAULT_THRESHOLD);
		exp_faulty[2] = 1'b1;
		check_state();
	endtask

	task automatic test_idle_gating();
		word_t a, b, m;
		mask_t masks;
		rand_word(m);
		masks    = '0;
		masks[1] = m | word_t'(1);
		masks[2] = m | word_t'(1);
		for (int n = 0; n < 3; n++) begin
			rand_word(a);
			rand_word(b);
			run_op(1'b0, ft_alu_pkg::ALU_OR, a, b, masks, 1'b0, 1'b0);
		end
		check_state();
	endtask

	task automatic test_reset();
		word_t a, b;
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		clear_expect();
		check_state();
		rand_word(a);
		rand_word(b);
		run_op(1'b1, ft_alu_pkg::ALU_ADD, a, b, '0, 1'b0, 1'b0);
	endtask

	initial begin
		rst_n      = 1'b0;
		enable     = 1'b0;
		op         = ft_alu_pkg::ALU_ADD;
		operand_a  = '0;
		operand_b  = '0;
		fault_mask = '0;
		cnt_idx    = '0;
		lfsr       = 32'ha6eb9410;
		clear_expect();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		test_fault_free();
		test_single_lane();
		test_perm_fault();
		test_spare_exhaust();
		test_idle_gating();
		test_reset();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule : ft_alu_tb

`default_nettype wire

// File: list.f
hdl/ft_alu_pkg.sv
hdl/alu_core.sv
hdl/tmr_voter.sv
hdl/fault_monitor.sv
hdl/ft_alu_top.sv
bench/ft_alu_props.sv
bench/ft_alu_tb.sv

// File: Bender.yml
package:
  name: ft_alu

sources:
  - hdl/ft_alu_pkg.sv
  - hdl/alu_core.sv
  - hdl/tmr_voter.sv
  - hdl/fault_monitor.sv
  - hdl/ft_alu_top.sv
  - target: test
    files:
      - bench/ft_alu_props.sv
      - bench/ft_alu_tb.sv
